//--- all.f
+incdir+sim
src/dp_pkg.sv
src/regfile.sv
src/function_unit.sv
src/load_store_unit.sv
src/data_mem.sv
src/datapath.sv
sim/tb_datapath.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_datapath
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= all.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# build and run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim/dp_model.svh
// reference model of the ALU, load/store lanes and writeback, included into the testbench
`ifndef DP_MODEL_SVH
`define DP_MODEL_SVH

function automatic word_t alu_model(input word_t a, input word_t b, input func_sel_t fs);
    case (fs)
        FS_ADD:  return a + b;
        FS_SUB:  return a - b;
        FS_SLL:  return a << b[4:0];
        FS_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        FS_SLTU: return (a < b) ? 32'd1 : 32'd0;
        FS_XOR:  return a ^ b;
        FS_SRL:  return a >> b[4:0];
        FS_SRA:  return word_t'($signed(a) >>> b[4:0]);
        FS_OR:   return a | b;
        FS_AND:  return a & b;
        default: return 32'd0;
    endcase
endfunction

// zero, carry, negative, overflow; carry on subtract means no borrow
function automatic flags_t flags_model(input word_t a, input word_t b, input func_sel_t fs);
    word_t s;
    logic  c;
    logic  v;
    s = alu_model(a, b, fs);
    c = 1'b0;
    v = 1'b0;
    if (fs == FS_ADD) begin
        c = ({1'b0, a} + {1'b0, b}) > 33'h0_ffff_ffff;
        v = (a[31] == b[31]) && (s[31] != a[31]);
    end else if (fs == FS_SUB) begin
        c = (a >= b);
        v = (a[31] != b[31]) && (s[31] != a[31]);
    end
    return {s == 32'd0, c, s[31], v};
endfunction

// new memory word after a store of the given width at byte offset off
function automatic word_t store_merge(input word_t old, input word_t data,
                                      input logic [2:0] width, input logic [1:0] off);
    word_t mask;
    word_t lane;
    if (width == W_BYTE) begin
        mask = 32'h0000_00ff << (8 * off);
        lane = {24'd0, data[7:0]} << (8 * off);
    end else if (width == W_HALF) begin
        mask = 32'h0000_ffff << (16 * off[1]);
        lane = {16'd0, data[15:0]} << (16 * off[1]);
    end else begin
        return data;
    end
    return (old & ~mask) | lane;
endfunction

function automatic word_t load_value(input word_t w, input logic [2:0] width,
                                     input logic [1:0] off);
    word_t sh;
    sh = w >> (8 * off);
    case (width)
        W_BYTE:   return {{24{sh[7]}}, sh[7:0]};
        W_HALF:   return {{16{sh[15]}}, sh[15:0]};
        W_BYTE_U: return {24'd0, sh[7:0]};
        W_HALF_U: return {16'd0, sh[15:0]};
        default:  return w;
    endcase
endfunction

function automatic bit writes_back(input inst_class_t cls);
    return cls != CLS_STORE && cls != CLS_BRANCH;
endfunction

`endif

//--- sim/tb_datapath.sv
// testbench for the datapath, random instruction stream checked against a reference model
`timescale 1ns/1ns

module tb_datapath;
    import dp_pkg::*;

    localparam int MEM_WORDS    = 128;
    localparam int DONE_TIMEOUT = 10;

    localparam func_sel_t FS_LIST [10] = '{FS_ADD, FS_SUB, FS_SLL, FS_SLT, FS_SLTU,
                                           FS_XOR, FS_SRL, FS_SRA, FS_OR, FS_AND};
    localparam inst_class_t UJ_LIST [4] = '{CLS_LUI, CLS_AUIPC, CLS_JAL, CLS_JALR};
    localparam logic [2:0] LD_LIST [5] = '{W_BYTE, W_HALF, W_WORD, W_BYTE_U, W_HALF_U};

    logic        clk;
    logic        rst;
    logic        issue;
    logic [22:0] cword;
    word_t       pc;
    word_t       imm;
    logic        done;
    word_t       result;
    word_t       rs1_value;
    flags_t      flags;

    integer seed;
    int     checks;
    int     errors;
    int     issued;
    int     done_seen;
    word_t  regs_m [32];
    word_t  mem_m [MEM_WORDS];

    `include "dp_model.svh"

    datapath #(
        .MEM_WORDS (MEM_WORDS)
    ) u_dut (
        .clk       (clk),
        .rst       (rst),
        .issue     (issue),
        .cword     (cword),
        .pc        (pc),
        .imm       (imm),
        .done      (done),
        .result    (result),
        .rs1_value (rs1_value),
        .flags     (flags)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // every done strobe is counted, matched against issues at the end
    always @(negedge clk) begin
        if (rst && done) begin
            done_seen++;
        end
    end

    function automatic int unsigned pick(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic word_t rand_word();
        return $random(seed);
    endfunction

    task automatic check(input string name, input word_t exp, input word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic finish_run();
        $display("checks %0d, errors %0d, instructions %0d", checks, errors, issued);
        if (errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    endtask

    task automatic idle_gap();
        int n;
        n = 1 + pick(2);
        repeat (n) @(posedge clk);
    endtask

    // issue one instruction at the current rising edge and check what comes back
    task automatic execute(input string test, input inst_class_t cls, input logic [2:0] f3,
                           input logic f7, input reg_addr_t rd, input reg_addr_t rs1,
                           input reg_addr_t rs2, input word_t pc_v, input word_t imm_v);
        func_sel_t fs;
        word_t     a;
        word_t     b;
        word_t     s;
        word_t     exp;
        int        widx;
        int        waits;
        bit        got;
        fs = (cls == CLS_REG || cls == CLS_IMM) ? {f3, f7} :
             (cls == CLS_BRANCH) ? FS_SUB : FS_ADD;
        if (cls == CLS_AUIPC || cls == CLS_JAL || cls == CLS_JALR)
            a = pc_v;
        else
            a = regs_m[rs1];
        if (cls == CLS_REG || cls == CLS_BRANCH)
            b = regs_m[rs2];
        else if (cls == CLS_JAL || cls == CLS_JALR)
            b = 32'd4;
        else
            b = imm_v;
        s    = alu_model(a, b, fs);
        widx = int'((s >> 2) % MEM_WORDS);
        if (cls == CLS_LOAD)
            exp = load_value(mem_m[widx], f3, s[1:0]);
        else if (cls == CLS_LUI)
            exp = imm_v;
        else
            exp = s;

        issue <= 1'b1;
        cword <= {rs2, rs1, rd, f7, f3, cls};
        pc    <= pc_v;
        imm   <= imm_v;
        issued++;
        @(posedge clk);
        issue <= 1'b0;

        // first negedge is cycle 1, done belongs in cycle 2
        waits = 0;
        got   = 1'b0;
        while (!got && waits < DONE_TIMEOUT) begin
            @(negedge clk);
            waits++;
            got = done;
        end
        if (!got) begin
            errors++;
            $display("ERROR: %s timed out, no done within %0d cycles of issue", test,
                     DONE_TIMEOUT);
            finish_run();
        end else begin
            check({test, " latency"}, 32'd2, 32'(waits));
            check({test, " result"}, exp, result);
            check({test, " rs1_value"}, regs_m[rs1], rs1_value);
            if (fs == FS_ADD || fs == FS_SUB)
                check({test, " flags"}, {28'd0, flags_model(a, b, fs)}, {28'd0, flags});
            if (cls == CLS_STORE)
                mem_m[widx] = store_merge(mem_m[widx], regs_m[rs2], f3, s[1:0]);
            if (writes_back(cls) && rd != 5'd0)
                regs_m[rd] = exp;
        end
    endtask

    initial begin : stimulus
        func_sel_t  fs;
        reg_addr_t  rd;
        logic [2:0] wid;
        int         w;
        int         off;
        seed      = 32'ha095_8caf;
        checks    = 0;
        errors    = 0;
        issued    = 0;
        done_seen = 0;
        for (int i = 0; i < 32; i++) begin
            regs_m[i] = '0;
        end
        rst   = 1'b0;
        issue = 1'b0;
        cword = '0;
        pc    = '0;
        imm   = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b1;
        @(posedge clk);

        // registers read zero out of reset, x0 ignores writes
        repeat (8) begin
            execute("reset read", CLS_REG, 3'd0, 1'b0, pick(32), pick(32), pick(32), 0, 0);
            idle_gap();
        end
        execute("x0 write", CLS_IMM, 3'd0, 1'b0, 5'd0, 5'd0, 5'd0, 0, rand_word());
        idle_gap();
        execute("x0 read", CLS_REG, 3'd0, 1'b0, pick(32), 5'd0, 5'd0, 0, 0);
        idle_gap();

        for (int r = 1; r < 32; r++) begin
            execute("reg init", CLS_IMM, 3'd0, 1'b0, r, 5'd0, 5'd0, 0, rand_word());
            idle_gap();
        end
        repeat (200) begin
            fs = FS_LIST[pick(10)];
            execute("alu", pick(2) ? CLS_REG : CLS_IMM, fs[3:1], fs[0], pick(32), pick(32),
                    pick(32), rand_word(), rand_word());
            idle_gap();
        end

        repeat (40) begin
            execute("upper jump", UJ_LIST[pick(4)], pick(8), pick(2), pick(32), pick(32),
                    pick(32), rand_word(), rand_word());
            idle_gap();
        end

        // branch leaves rd alone, the read after it shows the old value
        repeat (40) begin
            rd = pick(32);
            execute("branch", CLS_BRANCH, pick(8), 1'b0, rd, pick(32), pick(32),
                    rand_word(), rand_word());
            idle_gap();
            execute("branch read", CLS_REG, 3'd0, 1'b0, pick(32), rd, 5'd0, 0, 0);
            idle_gap();
        end

        for (int i = 0; i < MEM_WORDS; i++) begin
            execute("fill", CLS_STORE, W_WORD, 1'b0, pick(32), 5'd0, pick(32), 0, 4 * i);
            idle_gap();
        end
        repeat (150) begin
            w   = pick(MEM_WORDS);
            wid = pick(3);
            off = (wid == W_BYTE) ? pick(4) : (wid == W_HALF) ? 2 * pick(2) : 0;
            execute("store", CLS_STORE, wid, 1'b0, pick(32), 5'd0, pick(32), 0, 4 * w + off);
            idle_gap();
            wid = LD_LIST[pick(5)];
            off = (wid[1:0] == 2'd0) ? pick(4) : (wid[1:0] == 2'd1) ? 2 * pick(2) : 0;
            execute("load", CLS_LOAD, wid, 1'b0, pick(32), 5'd0, 5'd0, 0, 4 * w + off);
            idle_gap();
        end

        idle_gap();
        check("done count", 32'(issued), 32'(done_seen));
        finish_run();
    end

endmodule

//--- src/datapath.sv
// top of the execution datapath that takes one decoded instruction per issue strobe
`timescale 1ns/1ns

module datapath #(
    parameter int MEM_WORDS = 128
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           issue,
    input  logic [22:0]    cword,
    input  dp_pkg::word_t  pc,
    input  dp_pkg::word_t  imm,
    output logic           done,
    output dp_pkg::word_t  result,
    output dp_pkg::word_t  rs1_value,
    output dp_pkg::flags_t flags
);
    import dp_pkg::*;

    // control word fields
    inst_class_t in_cls;
    logic [2:0]  in_funct3;
    logic        in_funct7;
    reg_addr_t   in_rd;
    reg_addr_t   in_rs1;
    reg_addr_t   in_rs2;

    word_t       rf_rs1;
    word_t       rf_rs2;
    word_t       op_a;
    word_t       op_b;
    func_sel_t   op_fs;

    // stage 1 runs the function unit and the memory access
    logic        s1_valid;
    inst_class_t s1_cls;
    func_sel_t   s1_fs;
    reg_addr_t   s1_rd;
    logic [2:0]  s1_width;
    word_t       s1_a;
    word_t       s1_b;
    word_t       s1_imm;
    word_t       s1_rs1;
    word_t       s1_rs2;
    word_t       fu_s;
    flags_t      fu_flags;

    mem_addr_t   mem_addr;
    byte_en_t    mem_be;
    word_t       mem_wdata;
    word_t       mem_rdata;
    word_t       load_data;

    // stage 2 does the writeback
    logic        s2_valid;
    inst_class_t s2_cls;
    reg_addr_t   s2_rd;
    word_t       s2_res;
    flags_t      s2_flags;
    word_t       s2_rs1;
    logic        wb_en;

    assign in_cls    = cword[3:0];
    assign in_funct3 = cword[6:4];
    assign in_funct7 = cword[7];
    assign in_rd     = cword[12:8];
    assign in_rs1    = cword[17:13];
    assign in_rs2    = cword[22:18];

    regfile u_regfile (
        .clk      (clk),
        .rst      (rst),
        .rd_addr0 (in_rs1),
        .rd_addr1 (in_rs2),
        .rd_data0 (rf_rs1),
        .rd_data1 (rf_rs2),
        .wr_en    (wb_en),
        .wr_addr  (s2_rd),
        .wr_data  (result)
    );

    always_comb begin
        case (in_cls)
            CLS_AUIPC, CLS_JAL, CLS_JALR: op_a = pc;
            default:                      op_a = rf_rs1;
        endcase
        case (in_cls)
            CLS_REG, CLS_BRANCH: op_b = rf_rs2;
            CLS_JAL, CLS_JALR:   op_b = 32'd4;
            default:             op_b = imm;
        endcase
        // branch compares by subtract and only reg and imm use the decoded function
        case (in_cls)
            CLS_REG, CLS_IMM: op_fs = {in_funct3, in_funct7};
            CLS_BRANCH:       op_fs = FS_SUB;
            default:          op_fs = FS_ADD;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= issue;
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            s1_cls   <= in_cls;
            s1_fs    <= op_fs;
            s1_rd    <= in_rd;
            s1_width <= in_funct3;
            s1_a     <= op_a;
            s1_b     <= op_b;
            s1_imm   <= imm;
            s1_rs1   <= rf_rs1;
            s1_rs2   <= rf_rs2;
        end
        if (s1_valid) begin
            s2_cls   <= s1_cls;
            s2_rd    <= s1_rd;
            s2_res   <= (s1_cls == CLS_LUI) ? s1_imm : fu_s;
            s2_flags <= fu_flags;
            s2_rs1   <= s1_rs1;
        end
    end

    function_unit u_fu (
        .a     (s1_a),
        .b     (s1_b),
        .fs    (s1_fs),
        .s     (fu_s),
        .flags (fu_flags)
    );

    load_store_unit u_lsu (
        .clk        (clk),
        .rst        (rst),
        .addr       (fu_s),
        .store_data (s1_rs2),
        .width      (s1_width),
        .store      (s1_valid && s1_cls == CLS_STORE),
        .mem_addr   (mem_addr),
        .mem_be     (mem_be),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata),
        .load_data  (load_data)
    );

    data_mem #(
        .MEM_WORDS (MEM_WORDS)
    ) u_dmem (
        .clk   (clk),
        .addr  (mem_addr),
        .be    (mem_be),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

    // load data arrives combinationally in the done cycle
    assign result    = (s2_cls == CLS_LOAD) ? load_data : s2_res;
    assign wb_en     = s2_valid && s2_cls != CLS_STORE && s2_cls != CLS_BRANCH;
    assign done      = s2_valid;
    assign rs1_value = s2_rs1;
    assign flags     = s2_flags;

    // no hazard logic, so the pipe must be empty on every issue
    a_issue_spacing : assert property (
        @(posedge clk) disable iff (!rst)
        issue |-> (!s1_valid && !s2_valid)
    ) else $error("issue while an instruction is still in flight");

    // a finished instruction hands back known values
    a_done_known : assert property (
        @(posedge clk) disable iff (!rst)
        done |-> !$isunknown({result, rs1_value, flags})
    ) else $error("done with an unknown result, rs1 value or flags");

endmodule

//--- src/data_mem.sv
// word-addressed data memory, registered read and byte-lane write
`timescale 1ns/1ns

module data_mem #(
    parameter int MEM_WORDS = 128
) (
    input  logic              clk,
    input  dp_pkg::mem_addr_t addr,
    input  dp_pkg::byte_en_t  be,
    input  dp_pkg::word_t     wdata,
    output dp_pkg::word_t     rdata
);
    import dp_pkg::*;

    localparam int AW = $clog2(MEM_WORDS);

    word_t          mem [MEM_WORDS];
    logic [AW-1:0]  idx;

    // upper address bits wrap onto the array
    assign idx = addr[AW-1:0];

    always_ff @(posedge clk) begin
        for (int lane = 0; lane < 4; lane++) begin
            if (be[lane]) begin
                mem[idx][8*lane +: 8] <= wdata[8*lane +: 8];
            end
        end
    end

    // old contents come back when read and write share an edge
    always_ff @(posedge clk) begin
        rdata <= mem[idx];
    end

endmodule

//--- src/load_store_unit.sv
// byte lane steering for stores and extraction/extension of load data
`timescale 1ns/1ns

module load_store_unit (
    input  logic              clk,
    input  logic              rst,
    input  dp_pkg::word_t     addr,
    input  dp_pkg::word_t     store_data,
    input  logic [2:0]        width,
    input  logic              store,
    output dp_pkg::mem_addr_t mem_addr,
    output dp_pkg::byte_en_t  mem_be,
    output dp_pkg::word_t     mem_wdata,
    input  dp_pkg::word_t     mem_rdata,
    output dp_pkg::word_t     load_data
);
    import dp_pkg::*;

    logic [1:0] offset;
    logic [1:0] offset_q;
    logic [2:0] width_q;
    logic [7:0] ld_byte;
    logic [15:0] ld_half;

    assign offset   = addr[1:0];
    assign mem_addr = addr[31:2];

    // store path, data replicated so every lane holds the value
    always_comb begin
        case (width[1:0])
            W_BYTE[1:0]: mem_wdata = {4{store_data[7:0]}};
            W_HALF[1:0]: mem_wdata = {2{store_data[15:0]}};
            default:     mem_wdata = store_data;
        endcase
        if (!store)
            mem_be = 4'b0000;
        else if (width[1:0] == W_BYTE[1:0])
            mem_be = 4'b0001 << offset;
        else if (width[1:0] == W_HALF[1:0])
            mem_be = offset[1] ? 4'b1100 : 4'b0011;
        else
            mem_be = 4'b1111;
    end

    // offset and width line up with the registered memory read
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            offset_q <= '0;
            width_q  <= W_WORD;
        end else begin
            offset_q <= offset;
            width_q  <= width;
        end
    end

    assign ld_byte = mem_rdata[8*offset_q +: 8];
    assign ld_half = offset_q[1] ? mem_rdata[31:16] : mem_rdata[15:0];

    always_comb begin
        case (width_q)
            W_BYTE:   load_data = {{24{ld_byte[7]}}, ld_byte};
            W_HALF:   load_data = {{16{ld_half[15]}}, ld_half};
            W_BYTE_U: load_data = {24'd0, ld_byte};
            W_HALF_U: load_data = {16'd0, ld_half};
            default:  load_data = mem_rdata;
        endcase
    end

    a_store_aligned : assert property (
        @(posedge clk) disable iff (!rst)
        store |-> ((width[1:0] != W_HALF[1:0] || !offset[0]) &&
                   (width[1:0] != W_WORD[1:0] || offset == 2'b00))
    ) else $error("misaligned store, width %0d offset %0d", width, offset);

endmodule

//--- src/function_unit.sv
// combinational ALU for the datapath, op chosen by {funct3, funct7 bit}
`timescale 1ns/1ns

module function_unit (
    input  dp_pkg::word_t     a,
    input  dp_pkg::word_t     b,
    input  dp_pkg::func_sel_t fs,
    output dp_pkg::word_t     s,
    output dp_pkg::flags_t    flags
);
    import dp_pkg::*;

    logic        sub;
    logic        arith;
    word_t       b_eff;
    logic [32:0] sum;
    logic [4:0]  shamt;
    logic        carry;
    logic        ovf;

    assign sub   = (fs == FS_SUB);
    assign arith = (fs == FS_ADD) || sub;

    // subtract as a + ~b + 1
    assign b_eff = sub ? ~b : b;
    assign sum   = {1'b0, a} + {1'b0, b_eff} + {32'd0, sub};
    assign shamt = b[4:0];

    always_comb begin
        case (fs)
            FS_ADD,
            FS_SUB:  s = sum[31:0];
            FS_SLL:  s = a << shamt;
            FS_SLT:  s = {31'd0, $signed(a) < $signed(b)};
            FS_SLTU: s = {31'd0, a < b};
            FS_XOR:  s = a ^ b;
            FS_SRL:  s = a >> shamt;
            FS_SRA:  s = $signed(a) >>> shamt;
            FS_OR:   s = a | b;
            FS_AND:  s = a & b;
            default: s = '0;
        endcase
    end

    // carry and overflow only mean something on add/sub
    assign carry = arith & sum[32];
    assign ovf   = arith & (a[31] == b_eff[31]) & (sum[31] != a[31]);

    assign flags = {(s == '0), carry, s[31], ovf};

endmodule

//--- src/regfile.sv
// 32-entry register file with two combinational reads and one clocked write port
`timescale 1ns/1ns

module regfile (
    input  logic              clk,
    input  logic              rst,
    input  dp_pkg::reg_addr_t rd_addr0,
    input  dp_pkg::reg_addr_t rd_addr1,
    output dp_pkg::word_t     rd_data0,
    output dp_pkg::word_t     rd_data1,
    input  logic              wr_en,
    input  dp_pkg::reg_addr_t wr_addr,
    input  dp_pkg::word_t     wr_data
);
    import dp_pkg::*;

    // x0 has no storage
    word_t regs [1:31];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign rd_data0 = (rd_addr0 == '0) ? '0 : regs[rd_addr0];
    assign rd_data1 = (rd_addr1 == '0) ? '0 : regs[rd_addr1];

    // a write carries a known address and value
    a_wr_known : assert property (
        @(posedge clk) disable iff (!rst)
        wr_en |-> !$isunknown({wr_addr, wr_data})
    ) else $error("register write with an unknown address or data");

endmodule

//--- src/dp_pkg.sv
// shared types and constants for the datapath, imported by every RTL block
package dp_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [29:0] mem_addr_t;
    typedef logic [3:0]  byte_en_t;
    typedef logic [3:0]  inst_class_t;
    typedef logic [3:0]  func_sel_t;

    // zero, carry, negative, overflow from msb down
    typedef logic [3:0]  flags_t;

    // instruction classes as issued by the control unit
    localparam inst_class_t CLS_LOAD   = 4'd0;
    localparam inst_class_t CLS_IMM    = 4'd1;
    localparam inst_class_t CLS_STORE  = 4'd2;
    localparam inst_class_t CLS_REG    = 4'd3;
    localparam inst_class_t CLS_LUI    = 4'd4;
    localparam inst_class_t CLS_AUIPC  = 4'd5;
    localparam inst_class_t CLS_BRANCH = 4'd6;
    localparam inst_class_t CLS_JALR   = 4'd7;
    localparam inst_class_t CLS_JAL    = 4'd8;

    // function select is {funct3, funct7 bit}
    localparam func_sel_t FS_ADD  = 4'b000_0;
    localparam func_sel_t FS_SUB  = 4'b000_1;
    localparam func_sel_t FS_SLL  = 4'b001_0;
    localparam func_sel_t FS_SLT  = 4'b010_0;
    localparam func_sel_t FS_SLTU = 4'b011_0;
    localparam func_sel_t FS_XOR  = 4'b100_0;
    localparam func_sel_t FS_SRL  = 4'b101_0;
    localparam func_sel_t FS_SRA  = 4'b101_1;
    localparam func_sel_t FS_OR   = 4'b110_0;
    localparam func_sel_t FS_AND  = 4'b111_0;

    // load/store width codes, same as funct3
    localparam logic [2:0] W_BYTE   = 3'd0;
    localparam logic [2:0] W_HALF   = 3'd1;
    localparam logic [2:0] W_WORD   = 3'd2;
    localparam logic [2:0] W_BYTE_U = 3'd4;
    localparam logic [2:0] W_HALF_U = 3'd5;

endpackage
